// ==== Makefile ====
# Verilator build and run for the read-only AXI4 crossbar

VERILATOR  ?= verilator
TB_TOP     ?= axi_rd_xbar_tb
RTL_TOP    ?= axi_rd_xbar
FILELIST   ?= axi_rd_xbar.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== axi_rd_xbar.f ====
+incdir+include
design/axi_rd_xbar_pkg.sv
design/rr_arbiter.sv
design/ar_master_port.sv
design/ar_slave_select.sv
design/r_slave_port.sv
design/r_master_select.sv
design/axi_rd_xbar.sv
tb/axi_rd_xbar_tb.sv

// ==== design/ar_master_port.sv ====
//==========================================================================
// Master read-address port
// Captures a master AR request, widens its ID, decodes the target
// slave port and holds the request until the slave takes it
//==========================================================================
`timescale 1ns/1ps

module ar_master_port #(
	parameter int MASTER_IDX = 0
) (
	input  logic                   clk,
	input  logic                   rstn,
	input  axi_rd_xbar_pkg::m_ar_t ar_i,
	input  logic                   ar_valid_i,
	output logic                   ar_ready_o,
	output axi_rd_xbar_pkg::s_ar_t req_o,
	output logic                   req_valid_o,
	output axi_rd_xbar_pkg::sid_t  sel_o,
	output logic                   sel_valid_o,
	input  logic                   done_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_WAIT
	} state_t;

	state_t                 state;
	axi_rd_xbar_pkg::s_ar_t req_q;
	axi_rd_xbar_pkg::sid_t  sel_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ar_valid_i) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					// Slave port took the request
					if (done_i) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request payload and decoded target
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && ar_valid_i) begin
			req_q.addr <= ar_i.addr;
			req_q.id <= {axi_rd_xbar_pkg::mid_t'(MASTER_IDX), ar_i.id};
			req_q.len <= ar_i.len;
			req_q.size <= ar_i.size;
			req_q.burst <= ar_i.burst;
			req_q.prot <= ar_i.prot;
		end
		if (state == ST_DECODE) begin
			sel_q <= axi_rd_xbar_pkg::addr_to_slave(req_q.addr);
		end
	end

	assign ar_ready_o = (state == ST_IDLE);
	assign req_o = req_q;
	assign req_valid_o = (state == ST_WAIT);
	assign sel_o = sel_q;
	assign sel_valid_o = (state == ST_WAIT);

endmodule

// ==== design/ar_slave_select.sv ====
//==========================================================================
// Slave read-address select
// Arbitrates the masters aimed at one slave port and forwards the
// winning request
//==========================================================================
`timescale 1ns/1ps
`include "axi_rd_xbar_config.svh"

module ar_slave_select #(
	parameter int SLAVE_IDX = 0
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  axi_rd_xbar_pkg::s_ar_t      req_i [`XBAR_N_MASTERS],
	input  logic [`XBAR_N_MASTERS-1:0]  req_valid_i,
	input  axi_rd_xbar_pkg::sid_t       sel_i [`XBAR_N_MASTERS],
	input  logic [`XBAR_N_MASTERS-1:0]  sel_valid_i,
	output axi_rd_xbar_pkg::s_ar_t      s_ar_o,
	output logic                        s_ar_valid_o,
	input  logic                        s_ar_ready_i,
	output logic [`XBAR_N_MASTERS-1:0]  done_o
);

	logic [`XBAR_N_MASTERS-1:0] arb_req;
	logic                       gnt;
	axi_rd_xbar_pkg::mid_t      gnt_id;

	for (genvar m = 0; m < `XBAR_N_MASTERS; m++) begin : g_mst
		assign arb_req[m] = sel_valid_i[m] && (sel_i[m] == axi_rd_xbar_pkg::sid_t'(SLAVE_IDX));
		// Granted master learns of the transfer
		assign done_o[m] = s_ar_valid_o && s_ar_ready_i &&
			(gnt_id == axi_rd_xbar_pkg::mid_t'(m));
	end

	rr_arbiter #(.N_REQ(`XBAR_N_MASTERS)) u_arb (
		.clk     (clk),
		.rstn    (rstn),
		.req_i   (arb_req),
		.gnt_o   (gnt),
		.gnt_id_o(gnt_id)
	);

	assign s_ar_o = gnt ? req_i[gnt_id] : '0;
	assign s_ar_valid_o = gnt && req_valid_i[gnt_id];

endmodule

// ==== design/axi_rd_xbar.sv ====
//==========================================================================
// Read-only AXI4 crossbar
// N masters to N mapped slave ports plus one default port, with
// round-robin arbitration on both the AR and the R channels
//==========================================================================
`timescale 1ns/1ps
`include "axi_rd_xbar_config.svh"

module axi_rd_xbar (
	input  logic                        clk,
	input  logic                        rstn,
	input  axi_rd_xbar_pkg::m_ar_t      m_ar_i [`XBAR_N_MASTERS],
	input  logic [`XBAR_N_MASTERS-1:0]  m_ar_valid_i,
	output logic [`XBAR_N_MASTERS-1:0]  m_ar_ready_o,
	output axi_rd_xbar_pkg::m_r_t       m_r_o [`XBAR_N_MASTERS],
	output logic [`XBAR_N_MASTERS-1:0]  m_r_valid_o,
	input  logic [`XBAR_N_MASTERS-1:0]  m_r_ready_i,
	output axi_rd_xbar_pkg::s_ar_t      s_ar_o [`XBAR_N_SLAVES+1],
	output logic [`XBAR_N_SLAVES:0]     s_ar_valid_o,
	input  logic [`XBAR_N_SLAVES:0]     s_ar_ready_i,
	input  axi_rd_xbar_pkg::s_r_t       s_r_i [`XBAR_N_SLAVES+1],
	input  logic [`XBAR_N_SLAVES:0]     s_r_valid_i,
	output logic [`XBAR_N_SLAVES:0]     s_r_ready_o
);

	// Read-address links
	axi_rd_xbar_pkg::s_ar_t     mp_req [`XBAR_N_MASTERS];
	logic [`XBAR_N_MASTERS-1:0] mp_req_valid;
	axi_rd_xbar_pkg::sid_t      mp_sel [`XBAR_N_MASTERS];
	logic [`XBAR_N_MASTERS-1:0] mp_sel_valid;
	logic [`XBAR_N_MASTERS-1:0] mp_done;
	logic [`XBAR_N_MASTERS-1:0] slv_done [`XBAR_N_SLAVES+1];

	// Read-response links
	axi_rd_xbar_pkg::s_r_t      rp_beat [`XBAR_N_SLAVES+1];
	logic [`XBAR_N_SLAVES:0]    rp_beat_valid;
	axi_rd_xbar_pkg::mid_t      rp_mst [`XBAR_N_SLAVES+1];
	logic [`XBAR_N_SLAVES:0]    rp_mst_req;
	logic [`XBAR_N_SLAVES:0]    rp_granted;
	logic [`XBAR_N_SLAVES:0]    rp_beat_ready;
	logic [`XBAR_N_SLAVES:0]    ms_granted [`XBAR_N_MASTERS];
	logic [`XBAR_N_SLAVES:0]    ms_beat_ready [`XBAR_N_MASTERS];

	for (genvar m = 0; m < `XBAR_N_MASTERS; m++) begin : g_mst
		ar_master_port #(.MASTER_IDX(m)) u_ar_port (
			.clk        (clk),
			.rstn       (rstn),
			.ar_i       (m_ar_i[m]),
			.ar_valid_i (m_ar_valid_i[m]),
			.ar_ready_o (m_ar_ready_o[m]),
			.req_o      (mp_req[m]),
			.req_valid_o(mp_req_valid[m]),
			.sel_o      (mp_sel[m]),
			.sel_valid_o(mp_sel_valid[m]),
			.done_i     (mp_done[m])
		);

		// Done comes from the slave port this master aimed at
		assign mp_done[m] = slv_done[mp_sel[m]][m];

		r_master_select #(.MASTER_IDX(m)) u_r_sel (
			.clk         (clk),
			.rstn        (rstn),
			.beat_i      (rp_beat),
			.beat_valid_i(rp_beat_valid),
			.mst_i       (rp_mst),
			.mst_req_i   (rp_mst_req),
			.granted_o   (ms_granted[m]),
			.beat_ready_o(ms_beat_ready[m]),
			.m_r_o       (m_r_o[m]),
			.m_r_valid_o (m_r_valid_o[m]),
			.m_r_ready_i (m_r_ready_i[m])
		);
	end

	for (genvar s = 0; s <= `XBAR_N_SLAVES; s++) begin : g_slv
		ar_slave_select #(.SLAVE_IDX(s)) u_ar_sel (
			.clk         (clk),
			.rstn        (rstn),
			.req_i       (mp_req),
			.req_valid_i (mp_req_valid),
			.sel_i       (mp_sel),
			.sel_valid_i (mp_sel_valid),
			.s_ar_o      (s_ar_o[s]),
			.s_ar_valid_o(s_ar_valid_o[s]),
			.s_ar_ready_i(s_ar_ready_i[s]),
			.done_o      (slv_done[s])
		);

		r_slave_port u_r_port (
			.clk         (clk),
			.rstn        (rstn),
			.s_r_i       (s_r_i[s]),
			.s_r_valid_i (s_r_valid_i[s]),
			.s_r_ready_o (s_r_ready_o[s]),
			.beat_o      (rp_beat[s]),
			.beat_valid_o(rp_beat_valid[s]),
			.mst_o       (rp_mst[s]),
			.mst_req_o   (rp_mst_req[s]),
			.granted_i   (rp_granted[s]),
			.beat_ready_i(rp_beat_ready[s])
		);

		// Grant and ready from the master this port is serving
		assign rp_granted[s] = ms_granted[rp_mst[s]][s];
		assign rp_beat_ready[s] = ms_beat_ready[rp_mst[s]][s];
	end

endmodule

// ==== design/axi_rd_xbar_pkg.sv ====
//==========================================================================
// Read crossbar types
// Index and ID types, AR and R channel structs, address decode
//==========================================================================
`include "axi_rd_xbar_config.svh"

package axi_rd_xbar_pkg;

	// Master index bits, never less than one
	localparam int MID_W = (`XBAR_N_MASTERS > 1) ? $clog2(`XBAR_N_MASTERS) : 1;
	// Slave port index bits, default port included
	localparam int SID_W = (`XBAR_N_SLAVES + 1 > 1) ? $clog2(`XBAR_N_SLAVES + 1) : 1;

	typedef logic [MID_W-1:0] mid_t;
	typedef logic [SID_W-1:0] sid_t;
	// Master index sits above the original ID
	typedef logic [MID_W+`AXI_ID_W-1:0] xid_t;

	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [`AXI_ID_W-1:0]   id;
		logic [7:0]             len;
		logic [2:0]             size;
		logic [1:0]             burst;
		logic [2:0]             prot;
	} m_ar_t;

	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		xid_t                   id;
		logic [7:0]             len;
		logic [2:0]             size;
		logic [1:0]             burst;
		logic [2:0]             prot;
	} s_ar_t;

	typedef struct packed {
		xid_t                   id;
		logic [`AXI_DATA_W-1:0] data;
		logic [1:0]             resp;
		logic                   last;
	} s_r_t;

	typedef struct packed {
		logic [`AXI_ID_W-1:0]   id;
		logic [`AXI_DATA_W-1:0] data;
		logic [1:0]             resp;
		logic                   last;
	} m_r_t;

	// Unmapped addresses land on the default port
	function automatic sid_t addr_to_slave(input logic [`AXI_ADDR_W-1:0] addr);
		sid_t sel;
		sel = sid_t'(`XBAR_N_SLAVES);
		if (addr >= `XBAR_SLV0_BASE && addr <= `XBAR_SLV0_LAST) begin
			sel = sid_t'(0);
		end else if (addr >= `XBAR_SLV1_BASE && addr <= `XBAR_SLV1_LAST) begin
			sel = sid_t'(1);
		end
		return sel;
	endfunction

endpackage

// ==== design/r_master_select.sv ====
//==========================================================================
// Master read-response select
// Arbitrates the slave ports aimed at one master and returns their
// beats with the master index stripped from the ID
//==========================================================================
`timescale 1ns/1ps
`include "axi_rd_xbar_config.svh"

module r_master_select #(
	parameter int MASTER_IDX = 0
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  axi_rd_xbar_pkg::s_r_t       beat_i [`XBAR_N_SLAVES+1],
	input  logic [`XBAR_N_SLAVES:0]     beat_valid_i,
	input  axi_rd_xbar_pkg::mid_t       mst_i [`XBAR_N_SLAVES+1],
	input  logic [`XBAR_N_SLAVES:0]     mst_req_i,
	output logic [`XBAR_N_SLAVES:0]     granted_o,
	output logic [`XBAR_N_SLAVES:0]     beat_ready_o,
	output axi_rd_xbar_pkg::m_r_t       m_r_o,
	output logic                        m_r_valid_o,
	input  logic                        m_r_ready_i
);

	logic [`XBAR_N_SLAVES:0] arb_req;
	logic                    gnt;
	axi_rd_xbar_pkg::sid_t   gnt_id;
	axi_rd_xbar_pkg::s_r_t   sel_beat;

	for (genvar p = 0; p <= `XBAR_N_SLAVES; p++) begin : g_port
		assign arb_req[p] = mst_req_i[p] && (mst_i[p] == axi_rd_xbar_pkg::mid_t'(MASTER_IDX));
		assign granted_o[p] = gnt && (gnt_id == axi_rd_xbar_pkg::sid_t'(p));
		// Only the granted port sees the master's ready
		assign beat_ready_o[p] = granted_o[p] && m_r_ready_i;
	end

	rr_arbiter #(.N_REQ(`XBAR_N_SLAVES + 1)) u_arb (
		.clk     (clk),
		.rstn    (rstn),
		.req_i   (arb_req),
		.gnt_o   (gnt),
		.gnt_id_o(gnt_id)
	);

	assign sel_beat = beat_i[gnt_id];

	always_comb begin
		m_r_o = '0;
		if (gnt) begin
			m_r_o.id = sel_beat.id[`AXI_ID_W-1:0];
			m_r_o.data = sel_beat.data;
			m_r_o.resp = sel_beat.resp;
			m_r_o.last = sel_beat.last;
		end
	end

	assign m_r_valid_o = gnt && beat_valid_i[gnt_id];

endmodule

// ==== design/r_slave_port.sv ====
//==========================================================================
// Slave read-response port
// Registers the first beat of a burst, requests the target master
// and then streams the rest of the burst through
//==========================================================================
`timescale 1ns/1ps
`include "axi_rd_xbar_config.svh"

module r_slave_port (
	input  logic                  clk,
	input  logic                  rstn,
	input  axi_rd_xbar_pkg::s_r_t s_r_i,
	input  logic                  s_r_valid_i,
	output logic                  s_r_ready_o,
	output axi_rd_xbar_pkg::s_r_t beat_o,
	output logic                  beat_valid_o,
	output axi_rd_xbar_pkg::mid_t mst_o,
	output logic                  mst_req_o,
	input  logic                  granted_i,
	input  logic                  beat_ready_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_FIRST,
		ST_STREAM
	} state_t;

	state_t                state;
	axi_rd_xbar_pkg::s_r_t beat_q;
	axi_rd_xbar_pkg::mid_t mst_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (s_r_valid_i) begin
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (granted_i) begin
						state <= ST_FIRST;
					end
				end
				ST_FIRST: begin
					// Single-beat bursts end here
					if (beat_ready_i) begin
						state <= beat_q.last ? ST_IDLE : ST_STREAM;
					end
				end
				ST_STREAM: begin
					if (s_r_valid_i && beat_ready_i && s_r_i.last) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// First beat and its target master, from the upper ID bits
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && s_r_valid_i) begin
			beat_q <= s_r_i;
			mst_q <= s_r_i.id[`AXI_ID_W +: axi_rd_xbar_pkg::MID_W];
		end
	end

	always_comb begin
		s_r_ready_o = 1'b0;
		beat_o = '0;
		beat_valid_o = 1'b0;
		case (state)
			ST_IDLE: begin
				s_r_ready_o = 1'b1;
			end
			ST_FIRST: begin
				beat_o = beat_q;
				beat_valid_o = 1'b1;
			end
			ST_STREAM: begin
				// Straight through to the master
				s_r_ready_o = beat_ready_i;
				beat_o = s_r_i;
				beat_valid_o = s_r_valid_i;
			end
			default: begin
				s_r_ready_o = 1'b0;
			end
		endcase
	end

	assign mst_o = mst_q;
	assign mst_req_o = (state != ST_IDLE);

endmodule

// ==== design/rr_arbiter.sv ====
//==========================================================================
// Round-robin arbiter
// Registered grant, held while the granted requester keeps its request
//==========================================================================
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int N_REQ = 2,
	localparam int ID_W = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic [N_REQ-1:0] req_i,
	output logic             gnt_o,
	output logic [ID_W-1:0]  gnt_id_o
);

	logic            gnt_q;
	logic [ID_W-1:0] gnt_id_q;
	logic [ID_W-1:0] last_q;
	logic            pick_found;
	logic [ID_W-1:0] pick_id;

	// First request above the last winner, else the lowest request
	always_comb begin
		pick_found = 1'b0;
		pick_id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (!pick_found && req_i[i] && i > int'(last_q)) begin
				pick_found = 1'b1;
				pick_id = ID_W'(i);
			end
		end
		for (int i = 0; i < N_REQ; i++) begin
			if (!pick_found && req_i[i]) begin
				pick_found = 1'b1;
				pick_id = ID_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
			gnt_id_q <= '0;
			// Requester 0 wins the first round
			last_q <= ID_W'(N_REQ - 1);
		end else if (gnt_q) begin
			// Release once the owner drops its request
			if (!req_i[gnt_id_q]) begin
				gnt_q <= 1'b0;
			end
		end else if (pick_found) begin
			gnt_q <= 1'b1;
			gnt_id_q <= pick_id;
			last_q <= pick_id;
		end
	end

	assign gnt_o = gnt_q;
	assign gnt_id_o = gnt_id_q;

endmodule

// ==== include/axi_rd_xbar_config.svh ====
//==========================================================================
// Read-only AXI4 crossbar configuration
// Bus widths, port counts and the fixed slave address map
//==========================================================================
`ifndef AXI_RD_XBAR_CONFIG_SVH
`define AXI_RD_XBAR_CONFIG_SVH

// AXI bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4

// Port counts, slave port XBAR_N_SLAVES is the default port
`define XBAR_N_MASTERS 2
`define XBAR_N_SLAVES 2

// Inclusive address range of slave port 0
`define XBAR_SLV0_BASE 32'h0000_1000
`define XBAR_SLV0_LAST 32'h0000_1FFF

// Inclusive address range of slave port 1
`define XBAR_SLV1_BASE 32'h0000_2000
`define XBAR_SLV1_LAST 32'h0000_2FFF

`endif

// ==== tb/axi_rd_xbar_stimulus.txt ====
// Columns: master, address, ID, len, expected slave port, expected first data word
// Port 2 is the default port and answers with DECERR
0 00001000 3 3 0 00001000
1 00001100 5 1 0 00001100
0 00002040 1 0 1 00002040
1 00002200 a 7 1 00002200
0 00000400 2 2 2 00000400
1 00003000 f 1 2 00003000
0 00001200 4 5 0 00001200
1 00001300 6 3 0 00001300
0 00001400 7 0 0 00001400
1 00001500 8 2 0 00001500
0 00002800 9 3 1 00002800
1 00002ffc c 0 1 00002ffc
0 00001ffc d 1 0 00001ffc
1 00000ffc e 4 2 00000ffc
0 00004000 0 2 2 00004000
1 00002000 b 6 1 00002000

// ==== tb/axi_rd_xbar_tb.sv ====
//==========================================================================
// Read-only AXI4 crossbar testbench
// Master drivers and slave models run reads from the stimulus file
// under random ready and check routing, IDs, data and responses
//==========================================================================
`timescale 1ns/1ps
`include "axi_rd_xbar_config.svh"

module axi_rd_xbar_tb;

	localparam int NM = `XBAR_N_MASTERS;
	localparam int NP = `XBAR_N_SLAVES + 1;
	localparam int MAX_TXN = 32;
	localparam int COLS = 6;
	// Stimulus columns
	localparam int C_MST = 0;
	localparam int C_ADDR = 1;
	localparam int C_ID = 2;
	localparam int C_LEN = 3;
	localparam int C_PORT = 4;
	localparam int C_DATA = 5;

	logic                   clk;
	logic                   rstn;
	axi_rd_xbar_pkg::m_ar_t m_ar_i [NM];
	logic [NM-1:0]          m_ar_valid_i;
	logic [NM-1:0]          m_ar_ready_o;
	axi_rd_xbar_pkg::m_r_t  m_r_o [NM];
	logic [NM-1:0]          m_r_valid_o;
	logic [NM-1:0]          m_r_ready_i;
	axi_rd_xbar_pkg::s_ar_t s_ar_o [NP];
	logic [NP-1:0]          s_ar_valid_o;
	logic [NP-1:0]          s_ar_ready_i;
	axi_rd_xbar_pkg::s_r_t  s_r_i [NP];
	logic [NP-1:0]          s_r_valid_i;
	logic [NP-1:0]          s_r_ready_o;

	logic [31:0]            stim [MAX_TXN*COLS];
	logic [31:0]            lfsr;
	int                     n_txn;
	int                     max_len;
	int                     done_cnt;
	int                     err_cnt;
	int                     cycle_cnt;
	int                     cycle_limit;
	logic                   timed_out;
	// Master side bookkeeping
	logic [NM-1:0]          busy;
	int                     cur_txn [NM];
	int                     scan_pos [NM];
	int                     beat_idx [NM];
	// Accepted requests in order per slave port
	axi_rd_xbar_pkg::s_ar_t pend_q [NP][$];
	int                     slv_beat [NP];

	axi_rd_xbar UUT (
		.clk         (clk),
		.rstn        (rstn),
		.m_ar_i      (m_ar_i),
		.m_ar_valid_i(m_ar_valid_i),
		.m_ar_ready_o(m_ar_ready_o),
		.m_r_o       (m_r_o),
		.m_r_valid_o (m_r_valid_o),
		.m_r_ready_i (m_r_ready_i),
		.s_ar_o      (s_ar_o),
		.s_ar_valid_o(s_ar_valid_o),
		.s_ar_ready_i(s_ar_ready_i),
		.s_r_i       (s_r_i),
		.s_r_valid_i (s_r_valid_i),
		.s_r_ready_o (s_r_ready_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int next_txn(input int m, input int from);
		int found;
		found = -1;
		for (int t = from; t < n_txn; t++) begin
			if (found < 0 && stim[t*COLS+C_MST] == 32'(m)) begin
				found = t;
			end
		end
		return found;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	task automatic check_ar(input int p);
		int mst;
		int t;
		axi_rd_xbar_pkg::s_ar_t ar;
		ar = s_ar_o[p];
		// Owner found by its original ID, the IDs in the table are unique
		mst = -1;
		for (int m = 0; m < NM; m++) begin
			if (busy[m] &&
				stim[cur_txn[m]*COLS+C_ID][`AXI_ID_W-1:0] == ar.id[`AXI_ID_W-1:0]) begin
				mst = m;
			end
		end
		assert (mst >= 0)
			else report_problem($sformatf("Slave port %0d got a read that no master has open", p));
		if (mst >= 0) begin
			t = cur_txn[mst];
			assert (stim[t*COLS+C_PORT] == 32'(p))
				else report_mismatch($sformatf("read %0d reached port %0d", t, p));
			assert (ar.addr == stim[t*COLS+C_ADDR] && ar.len == stim[t*COLS+C_LEN][7:0])
				else report_mismatch($sformatf("read %0d address or len changed", t));
			assert (ar.size == 3'd2 && ar.burst == 2'b01 && ar.prot == 3'(t))
				else report_mismatch($sformatf("read %0d size, burst or prot changed", t));
			assert (ar.id == {axi_rd_xbar_pkg::mid_t'(stim[t*COLS+C_MST]),
				stim[t*COLS+C_ID][`AXI_ID_W-1:0]})
				else report_mismatch($sformatf("read %0d widened ID is %h", t, ar.id));
		end
	endtask

	// One slave model per port answering in order with len+1 beats
	task automatic serve_slave(input int p);
		axi_rd_xbar_pkg::s_ar_t ar;
		axi_rd_xbar_pkg::s_r_t beat;
		if (s_r_valid_i[p] && s_r_ready_o[p]) begin
			if (slv_beat[p] >= int'(pend_q[p][0].len)) begin
				void'(pend_q[p].pop_front());
				slv_beat[p] = 0;
			end else begin
				slv_beat[p] = slv_beat[p] + 1;
			end
		end
		if (s_ar_valid_o[p] && s_ar_ready_i[p]) begin
			check_ar(p);
			pend_q[p].push_back(s_ar_o[p]);
		end
		lfsr = lfsr_next(lfsr);
		s_ar_ready_i[p] <= lfsr[0];
		if (pend_q[p].size() > 0) begin
			ar = pend_q[p][0];
			beat.id = ar.id;
			beat.data = ar.addr + 32'(4 * slv_beat[p]);
			beat.resp = (p == `XBAR_N_SLAVES) ? 2'b11 : 2'b00;
			beat.last = (slv_beat[p] == int'(ar.len));
			s_r_i[p] <= beat;
			s_r_valid_i[p] <= 1'b1;
		end else begin
			s_r_valid_i[p] <= 1'b0;
		end
	endtask

	task automatic check_beat(input int m);
		int t;
		logic [31:0] exp_data;
		logic [1:0] exp_resp;
		logic exp_last;
		t = cur_txn[m];
		assert (busy[m])
			else report_problem($sformatf("Master %0d received a read beat with no read open", m));
		if (busy[m]) begin
			exp_data = stim[t*COLS+C_DATA] + 32'(4 * beat_idx[m]);
			exp_resp = (stim[t*COLS+C_PORT] == `XBAR_N_SLAVES) ? 2'b11 : 2'b00;
			exp_last = (beat_idx[m] == int'(stim[t*COLS+C_LEN][7:0]));
			assert (m_r_o[m].id == stim[t*COLS+C_ID][`AXI_ID_W-1:0])
				else report_mismatch($sformatf("read %0d beat ID %h", t, m_r_o[m].id));
			assert (m_r_o[m].data == exp_data)
				else report_mismatch($sformatf("read %0d beat %0d data %h, expected %h",
					t, beat_idx[m], m_r_o[m].data, exp_data));
			assert (m_r_o[m].resp == exp_resp)
				else report_mismatch($sformatf("read %0d resp %0d", t, m_r_o[m].resp));
			assert (m_r_o[m].last == exp_last)
				else report_mismatch($sformatf("read %0d last wrong on beat %0d", t, beat_idx[m]));
			if (m_r_o[m].last) begin
				busy[m] = 1'b0;
				done_cnt++;
			end else begin
				beat_idx[m] = beat_idx[m] + 1;
			end
		end
	endtask

	// One read open per master at a time
	task automatic drive_master(input int m);
		int t;
		axi_rd_xbar_pkg::m_ar_t ar;
		if (m_r_valid_o[m] && m_r_ready_i[m]) begin
			check_beat(m);
		end
		if (m_ar_valid_i[m] && m_ar_ready_o[m]) begin
			m_ar_valid_i[m] <= 1'b0;
		end else if (!busy[m]) begin
			t = next_txn(m, scan_pos[m]);
			if (t >= 0) begin
				ar.addr = stim[t*COLS+C_ADDR];
				ar.id = stim[t*COLS+C_ID][`AXI_ID_W-1:0];
				ar.len = stim[t*COLS+C_LEN][7:0];
				ar.size = 3'd2;
				ar.burst = 2'b01;
				ar.prot = 3'(t);
				m_ar_i[m] <= ar;
				m_ar_valid_i[m] <= 1'b1;
				busy[m] = 1'b1;
				cur_txn[m] = t;
				scan_pos[m] = t + 1;
				beat_idx[m] = 0;
			end
		end
		lfsr = lfsr_next(lfsr);
		m_r_ready_i[m] <= lfsr[0];
	endtask

	always @(posedge clk) begin
		if (rstn) begin
			for (int p = 0; p < NP; p++) begin
				serve_slave(p);
			end
			for (int m = 0; m < NM; m++) begin
				drive_master(m);
			end
		end
	end

	initial begin
		rstn <= 1'b0;
		m_ar_valid_i <= '0;
		m_r_ready_i <= '0;
		s_ar_ready_i <= '0;
		s_r_valid_i <= '0;
		for (int i = 0; i < NM; i++) begin
			m_ar_i[i] <= '0;
			busy[i] = 1'b0;
			cur_txn[i] = -1;
			scan_pos[i] = 0;
			beat_idx[i] = 0;
		end
		for (int i = 0; i < NP; i++) begin
			s_r_i[i] <= '0;
			slv_beat[i] = 0;
		end
		lfsr = 32'h134fb155;
		err_cnt = 0;
		done_cnt = 0;
		cycle_cnt = 0;
		// Unused entries keep all ones and end the table
		for (int i = 0; i < MAX_TXN*COLS; i++) begin
			stim[i] = '1;
		end
		$readmemh("tb/axi_rd_xbar_stimulus.txt", stim);
		n_txn = 0;
		max_len = 0;
		while (n_txn < MAX_TXN && stim[n_txn*COLS+C_MST] != '1) begin
			if (int'(stim[n_txn*COLS+C_LEN][7:0]) > max_len) begin
				max_len = int'(stim[n_txn*COLS+C_LEN][7:0]);
			end
			n_txn++;
		end
		cycle_limit = n_txn * ((max_len + 1) * 8 + 20) + 100;
		repeat (5) @(posedge clk);
		assert (m_ar_ready_o == '1 && s_ar_valid_o == '0 && m_r_valid_o == '0)
			else report_mismatch("outputs not in reset state");
		rstn <= 1'b1;
		while (done_cnt < n_txn && cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		timed_out = (done_cnt < n_txn);
		if (timed_out) begin
			$display("Timeout after %0d cycles, reads were still open", cycle_cnt);
		end
		for (int p = 0; p < NP; p++) begin
			assert (pend_q[p].size() == 0)
				else report_mismatch($sformatf("port %0d still holds reads", p));
		end
		$display("Checks failed: %0d, timeouts: %0d, reads done: %0d of %0d",
			err_cnt, timed_out ? 1 : 0, done_cnt, n_txn);
		if (err_cnt == 0 && !timed_out) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
